// ==== MontSetup.f ====
verilog/MontPkg.sv
verilog/QRegCal.sv
verilog/MontWbRegs.sv
verilog/MontSetupTop.sv
testbench/MontSetupTb_assert.sv
testbench/MontSetupTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := MontSetupTb
RTL_TOP    := MontSetupTop
FILELIST   := MontSetup.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed
SOURCES    := $(shell grep -v '^+' $(FILELIST))

VFLAGS     := --binary --timing --assert --timescale 1ns/100ps -j 0 \
              --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps \
              --top-module $(TOP) -f $(FILELIST)
RUN_FLAGS  := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/MontSetupTb.sv ====
/*
  Testbench for the Montgomery setup stage.
  Drives Wishbone on the falling edge and checks reset state, register access,
  busy protection, interrupt handling and the rule N*Q mod 2^256 = 1.
*/
`default_nettype none

module MontSetupTb;
    timeunit 1ns;
    timeprecision 100ps;

    import MontPkg::*;

    // Seven engine runs over all tests
    localparam int NumCalcs       = 7;
    localparam int WatchdogCycles = NumCalcs * 1400 + 2000;
    localparam int AckLimit       = 16;
    localparam int WaitLimit      = 1500;

    logic                Clk;
    logic                Resetn;
    logic                WbCyc;
    logic                WbStb;
    logic                WbWe;
    logic [AdrWidth-1:0] WbAdr;
    logic [BusWidth-1:0] WbDatW;
    logic [BusWidth-1:0] WbDatR;
    logic                WbAck;
    logic                Irq;

    logic [31:0]             RngState;
    int                      ErrorCount;
    int                      TestStartErrors;
    int                      TestsPassed;
    int                      TestsFailed;
    int                      AssertFails;
    logic [OperandWidth-1:0] ModN;
    logic [OperandWidth-1:0] OtherN;
    logic [OperandWidth-1:0] ResQ;
    logic [BusWidth-1:0]     Word;

    MontSetupTop MontSetupTop_inst (
        .Clk    (Clk),
        .Resetn (Resetn),
        .WbCyc  (WbCyc),
        .WbStb  (WbStb),
        .WbWe   (WbWe),
        .WbAdr  (WbAdr),
        .WbDatW (WbDatW),
        .WbDatR (WbDatR),
        .WbAck  (WbAck),
        .Irq    (Irq)
    );

    // 8 ns period
    always #4 Clk = ~Clk;

    function automatic logic [31:0] XorShift32(input logic [31:0] X);
        logic [31:0] Y;
        Y = X ^ (X << 13);
        Y = Y ^ (Y >> 17);
        Y = Y ^ (Y << 5);
        return Y;
    endfunction

    function automatic logic [AdrWidth-1:0] WordAdr(input logic [AdrWidth-1:0] Base,
                                                    input int Idx);
        return Base + AdrWidth'(Idx * 4);
    endfunction

    task automatic RandomModulus(output logic [OperandWidth-1:0] N);
        for (int i = 0; i < BusWords; i++) begin
            RngState = XorShift32(RngState);
            N[BusWidth*i +: BusWidth] = RngState;
        end
        // Only odd moduli have an inverse
        N[0] = 1'b1;
    endtask

    // One classic cycle, request held until the ack shows up
    task automatic BusCycle(input logic We, input logic [AdrWidth-1:0] Adr,
                            input logic [BusWidth-1:0] WData,
                            output logic [BusWidth-1:0] RData);
        int Cycles;
        @(negedge Clk);
        WbCyc  = 1'b1;
        WbStb  = 1'b1;
        WbWe   = We;
        WbAdr  = Adr;
        WbDatW = WData;
        Cycles = 0;
        @(negedge Clk);
        while (!WbAck && Cycles < AckLimit) begin
            @(negedge Clk);
            Cycles++;
        end
        RData = WbDatR;
        if (!WbAck) begin
            $display("Bus access to address 0x%h was never acknowledged", Adr);
            ErrorCount++;
        end
        WbCyc = 1'b0;
        WbStb = 1'b0;
        WbWe  = 1'b0;
    endtask

    task automatic WbWrite(input logic [AdrWidth-1:0] Adr, input logic [BusWidth-1:0] Data);
        logic [BusWidth-1:0] Unused;
        BusCycle(1'b1, Adr, Data, Unused);
    endtask

    task automatic WbRead(input logic [AdrWidth-1:0] Adr, output logic [BusWidth-1:0] Data);
        BusCycle(1'b0, Adr, '0, Data);
    endtask

    task automatic ExpectWord(input logic [BusWidth-1:0] Got, input logic [BusWidth-1:0] Exp,
                              input string What);
        assert (Got == Exp) else begin
            $display("ERROR at %0t: %s is 0x%h, expected 0x%h", $time, What, Got, Exp);
            ErrorCount++;
        end
    endtask

    task automatic ExpectOperand(input logic [OperandWidth-1:0] Got,
                                 input logic [OperandWidth-1:0] Exp, input string What);
        assert (Got == Exp) else begin
            $display("ERROR at %0t: %s is 0x%h, expected 0x%h", $time, What, Got, Exp);
            ErrorCount++;
        end
    endtask

    // Low 256 bits of N*Q must be 1
    task automatic CheckInverse(input logic [OperandWidth-1:0] N,
                                input logic [OperandWidth-1:0] Q);
        logic [OperandWidth-1:0] Prod;
        Prod = N * Q;
        ExpectOperand(Prod, OperandWidth'(1), "N*Q mod 2^256");
    endtask

    task automatic WriteModulus(input logic [OperandWidth-1:0] N);
        for (int i = 0; i < BusWords; i++) begin
            WbWrite(WordAdr(ModulusBase, i), N[BusWidth*i +: BusWidth]);
        end
    endtask

    task automatic ReadWords(input logic [AdrWidth-1:0] Base,
                             output logic [OperandWidth-1:0] Value);
        logic [BusWidth-1:0] W;
        for (int i = 0; i < BusWords; i++) begin
            WbRead(WordAdr(Base, i), W);
            Value[BusWidth*i +: BusWidth] = W;
        end
    endtask

    task automatic PollDone();
        logic [BusWidth-1:0] Status;
        int Reads;
        Reads  = 0;
        Status = '0;
        while (!Status[StatusDoneBit] && Reads < WaitLimit) begin
            WbRead(StatusReg, Status);
            Reads++;
        end
        if (!Status[StatusDoneBit]) begin
            $display("Engine never reported done while the status register was polled");
            ErrorCount++;
        end
    endtask

    // Start, check the cleared flags, then wait on the interrupt line
    task automatic RunWithIrq(input logic [OperandWidth-1:0] N,
                              output logic [OperandWidth-1:0] Q);
        logic [BusWidth-1:0] Status;
        int Cycles;
        WriteModulus(N);
        WbWrite(CtrlReg, 32'h1);
        WbRead(StatusReg, Status);
        ExpectWord(Status, 32'h1, "Status after start");
        ExpectWord(BusWidth'(Irq), '0, "Irq after start");
        Cycles = 0;
        while (!Irq && Cycles < WaitLimit) begin
            @(negedge Clk);
            Cycles++;
        end
        if (!Irq) begin
            $display("Irq never rose after the calculation was started");
            ErrorCount++;
        end
        WbRead(StatusReg, Status);
        ExpectWord(Status, 32'h2, "Status after Irq");
        ReadWords(InverseBase, Q);
    endtask

    task automatic FinishTest(input string Name);
        if (ErrorCount == TestStartErrors) begin
            TestsPassed++;
            $display("Test %s: PASS", Name);
        end else begin
            TestsFailed++;
            $display("Test %s: FAIL", Name);
        end
        TestStartErrors = ErrorCount;
    endtask

    initial begin
        Clk             = 1'b0;
        Resetn          = 1'b0;
        WbCyc           = 1'b0;
        WbStb           = 1'b0;
        WbWe            = 1'b0;
        WbAdr           = '0;
        WbDatW          = '0;
        RngState        = 32'd80;
        ErrorCount      = 0;
        TestStartErrors = 0;
        TestsPassed     = 0;
        TestsFailed     = 0;
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        Resetn = 1'b1;

        // Flags clear, Q resets to 1, unmapped space reads zero
        ExpectWord(BusWidth'(Irq), '0, "Irq after reset");
        WbRead(StatusReg, Word);
        ExpectWord(Word, '0, "Status after reset");
        ReadWords(InverseBase, ResQ);
        ExpectOperand(ResQ, OperandWidth'(1), "Q after reset");
        WbRead(8'h20, Word);
        ExpectWord(Word, '0, "Unmapped word 0x20");
        WbRead(8'hC4, Word);
        ExpectWord(Word, '0, "Unmapped word 0xC4");
        FinishTest("reset state");

        RandomModulus(ModN);
        WriteModulus(ModN);
        ReadWords(ModulusBase, OtherN);
        ExpectOperand(OtherN, ModN, "Modulus readback");
        // Q words are read only
        for (int i = 0; i < BusWords; i++) begin
            RngState = XorShift32(RngState);
            WbWrite(WordAdr(InverseBase, i), RngState);
        end
        ReadWords(InverseBase, ResQ);
        ExpectOperand(ResQ, OperandWidth'(1), "Q after writes");
        FinishTest("modulus registers");

        repeat (3) begin
            RandomModulus(ModN);
            WriteModulus(ModN);
            WbWrite(CtrlReg, 32'h1);
            PollDone();
            ReadWords(InverseBase, ResQ);
            CheckInverse(ModN, ResQ);
        end
        FinishTest("inversion");

        // Restart and modulus writes land while the engine runs
        RandomModulus(ModN);
        WriteModulus(ModN);
        WbWrite(CtrlReg, 32'h1);
        WbWrite(CtrlReg, 32'h1);
        RandomModulus(OtherN);
        WriteModulus(OtherN);
        WbRead(StatusReg, Word);
        ExpectWord(Word, 32'h1, "Status while busy");
        ReadWords(ModulusBase, OtherN);
        ExpectOperand(OtherN, ModN, "Modulus after busy writes");
        PollDone();
        ReadWords(InverseBase, ResQ);
        CheckInverse(ModN, ResQ);
        WbRead(StatusReg, Word);
        ExpectWord(Word, 32'h2, "Status after busy run");
        FinishTest("busy protection");

        RandomModulus(ModN);
        RunWithIrq(ModN, ResQ);
        CheckInverse(ModN, ResQ);
        RunWithIrq(OperandWidth'(1), ResQ);
        ExpectOperand(ResQ, OperandWidth'(1), "Q for N = 1");
        RunWithIrq('1, ResQ);
        ExpectOperand(ResQ, '1, "Q for N = 2^256-1");
        CheckInverse('1, ResQ);
        FinishTest("interrupt and flags");

        repeat (4) @(negedge Clk);
        AssertFails = MontSetupTop_inst.uRegs.uAssert.FailCount;
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 TestsPassed, TestsFailed, AssertFails);
        if (TestsFailed == 0 && ErrorCount == 0 && AssertFails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Budget of 1400 cycles per engine run plus margin for bus traffic
    initial begin
        repeat (WatchdogCycles) @(posedge Clk);
        $display("Run timed out after %0d clock cycles before all tests finished",
                 WatchdogCycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/MontSetupTb_assert.sv ====
/*
  Concurrent checks on the Wishbone ack and the engine done pulse.
  Bound into MontWbRegs, failures show up through $error and a counter.
*/
`default_nettype none

module MontSetupTb_assert (
    input logic Clk,
    input logic Resetn,
    input logic WbCyc,
    input logic WbStb,
    input logic WbAck,
    input logic Done,
    input logic Irq,
    input logic Busy
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failed assertions so far, read by the testbench summary
    int FailCount = 0;

    // Registered ack is a single-cycle pulse
    AckOneCycle: assert property (@(posedge Clk) disable iff (!Resetn) WbAck |=> !WbAck)
        else begin
            $error("WbAck stayed high for more than one cycle");
            FailCount++;
        end

    // Ack only in the cycle after a request
    AckAfterReq: assert property (@(posedge Clk) disable iff (!Resetn)
        WbAck |-> $past(WbCyc && WbStb))
        else begin
            $error("WbAck rose without a request in the previous cycle");
            FailCount++;
        end

    // Engine completion pulse
    DoneOneCycle: assert property (@(posedge Clk) disable iff (!Resetn) Done |=> !Done)
        else begin
            $error("Done stayed high for more than one cycle");
            FailCount++;
        end

    // Flags come out of reset cleared
    ResetFlags: assert property (@(posedge Clk) $rose(Resetn) |-> !Irq && !Busy)
        else begin
            $error("Irq or busy set in the first cycle after reset");
            FailCount++;
        end

endmodule

bind MontWbRegs MontSetupTb_assert uAssert (
    .Clk    (Clk),
    .Resetn (Resetn),
    .WbCyc  (WbCyc),
    .WbStb  (WbStb),
    .WbAck  (WbAck),
    .Done   (Done),
    .Irq    (Irq),
    .Busy   (Busy)
);

`default_nettype wire

// ==== verilog/MontSetupTop.sv ====
/*
  Top level of the Montgomery setup stage.
  Wishbone register block in front of the bit-serial Q engine, Irq on completion.
*/
`default_nettype none

module MontSetupTop (
    input  logic                         Clk,
    input  logic                         Resetn,
    input  logic                         WbCyc,
    input  logic                         WbStb,
    input  logic                         WbWe,
    input  logic [MontPkg::AdrWidth-1:0] WbAdr,
    input  logic [MontPkg::BusWidth-1:0] WbDatW,
    output logic [MontPkg::BusWidth-1:0] WbDatR,
    output logic                         WbAck,
    output logic                         Irq
);
    import MontPkg::*;

    // Engine handshake
    logic [OperandWidth-1:0] Modulus;
    logic [OperandWidth-1:0] Inverse;
    logic                    Start;
    logic                    Done;

    MontWbRegs uRegs (
        .Clk     (Clk),
        .Resetn  (Resetn),
        .WbCyc   (WbCyc),
        .WbStb   (WbStb),
        .WbWe    (WbWe),
        .WbAdr   (WbAdr),
        .WbDatW  (WbDatW),
        .WbDatR  (WbDatR),
        .WbAck   (WbAck),
        .Modulus (Modulus),
        .Start   (Start),
        .Inverse (Inverse),
        .Done    (Done),
        .Irq     (Irq)
    );

    QRegCal uQCal (
        .Clk     (Clk),
        .Resetn  (Resetn),
        .Modulus (Modulus),
        .Start   (Start),
        .Inverse (Inverse),
        .Done    (Done)
    );

endmodule

`default_nettype wire

// ==== verilog/MontWbRegs.sv ====
/*
  Wishbone classic slave for the Montgomery setup stage.
  Holds the modulus words, control, status and the read-only result words.
  Every access is acknowledged one cycle after the request, writes are full words.
*/
`default_nettype none

module MontWbRegs (
    input  logic                             Clk,
    input  logic                             Resetn,
    input  logic                             WbCyc,
    input  logic                             WbStb,
    input  logic                             WbWe,
    input  logic [MontPkg::AdrWidth-1:0]     WbAdr,
    input  logic [MontPkg::BusWidth-1:0]     WbDatW,
    output logic [MontPkg::BusWidth-1:0]     WbDatR,
    output logic                             WbAck,
    output logic [MontPkg::OperandWidth-1:0] Modulus,
    output logic                             Start,
    input  logic [MontPkg::OperandWidth-1:0] Inverse,
    input  logic                             Done,
    output logic                             Irq
);
    import MontPkg::*;

    // New request, a held request is not taken again in its ack cycle
    logic Req;
    logic WrReq;

    // Address decode
    RegSel                   WordSel;
    RegSel                   BlockSel;
    logic [WordIdxWidth-1:0] WordIdx;
    logic                    CtrlHit;
    logic                    StatusHit;
    logic                    ModHit;
    logic                    InvHit;

    // Engine handshake state
    logic Busy;
    logic DoneFlag;
    logic Locked;

    logic [BusWords-1:0][BusWidth-1:0] ModWords;
    logic [BusWords-1:0][BusWidth-1:0] InvWords;
    logic [BusWidth-1:0]               ReadData;

    assign Req   = WbCyc && WbStb && !WbAck;
    assign WrReq = Req && WbWe;

    // Byte offset bits are ignored
    assign WordSel  = RegSel'({WbAdr[AdrWidth-1:WordLsb], {WordLsb{1'b0}}});
    // Base of the eight-word block
    assign BlockSel = RegSel'({WbAdr[AdrWidth-1:BlockLsb], {BlockLsb{1'b0}}});
    assign WordIdx  = WbAdr[BlockLsb-1:WordLsb];

    assign CtrlHit   = WordSel == CtrlReg;
    assign StatusHit = WordSel == StatusReg;
    assign ModHit    = BlockSel == ModulusBase;
    assign InvHit    = BlockSel == InverseBase;

    // Also covers the Start cycle, before Busy is set
    assign Locked = Busy || Start;

    assign InvWords = Inverse;
    assign Modulus  = ModWords;
    assign Irq      = DoneFlag;

    // Read mux, CtrlReg and unmapped addresses read as zero
    always_comb begin
        ReadData = '0;
        if (StatusHit) begin
            ReadData[StatusBusyBit] = Busy;
            ReadData[StatusDoneBit] = DoneFlag;
        end else if (ModHit) begin
            ReadData = ModWords[WordIdx];
        end else if (InvHit) begin
            ReadData = InvWords[WordIdx];
        end
    end

    // Ack, start pulse and flags
    always_ff @(posedge Clk or negedge Resetn) begin
        if (!Resetn) begin
            WbAck    <= 1'b0;
            Start    <= 1'b0;
            Busy     <= 1'b0;
            DoneFlag <= 1'b0;
        end else begin
            WbAck <= Req;
            // Start lines up with the ack of the CtrlReg write
            Start <= WrReq && CtrlHit && WbDatW[CtrlStartBit] && !Locked;
            if (Start) begin
                Busy <= 1'b1;
            end else if (Done) begin
                Busy <= 1'b0;
            end
            // Sticky until the next start
            if (Start) begin
                DoneFlag <= 1'b0;
            end else if (Done) begin
                DoneFlag <= 1'b1;
            end
        end
    end

    // Read data and modulus words
    always_ff @(posedge Clk) begin
        if (Req) begin
            WbDatR <= ReadData;
        end
        // Modulus stays fixed while the engine runs
        if (WrReq && ModHit && !Locked) begin
            ModWords[WordIdx] <= WbDatW;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/QRegCal.sv ====
/*
  Bit-serial engine that finds Q with N*Q mod 2^OperandWidth = 1 for an odd N.
  Pulse Start with Modulus held steady, Inverse is complete when Done pulses.
  One result bit per LimbCount+1 cycles, one difference limb updated per cycle.
*/
`default_nettype none

module QRegCal (
    input  logic                             Clk,
    input  logic                             Resetn,
    input  logic [MontPkg::OperandWidth-1:0] Modulus,
    input  logic                             Start,
    output logic [MontPkg::OperandWidth-1:0] Inverse,
    output logic                             Done
);
    import MontPkg::*;

    QCalState               State;
    QCalState               NextState;
    logic [SubCntWidth-1:0] SubCnt;
    logic [BitCntWidth-1:0] BitCnt;
    logic                   SubLast;
    logic                   BitLast;
    logic                   LimbStep;

    // Running difference D, two's complement over LimbCount+1 limbs
    logic [LimbCount:0][LimbWidth-1:0] Diff;
    // D >>> 1 and N >> 1, both split into limbs
    logic [LimbCount:0][LimbWidth-1:0] DiffShift;
    logic [LimbCount:0][LimbWidth-1:0] ModShift;

    // Current result bit, decides whether N is subtracted this pass
    logic                 QBit;
    logic                 Carry;
    logic                 CarryIn;
    logic [LimbWidth-1:0] CurDiff;
    logic [LimbWidth-1:0] CurMod;
    logic [LimbWidth-1:0] Term;
    logic [LimbWidth:0]   LimbSum;

    // Control FSM
    always_ff @(posedge Clk or negedge Resetn) begin
        if (!Resetn) begin
            State <= Idle;
        end else begin
            State <= NextState;
        end
    end

    always_comb begin
        NextState = State;
        unique case (State)
            Idle: begin
                if (Start) begin
                    NextState = Calc;
                end
            end
            Calc: begin
                // Last sub-step of the last bit
                if (SubLast && BitLast) begin
                    NextState = Finish;
                end
            end
            Finish: NextState = Idle;
            default: NextState = Idle;
        endcase
    end

    assign SubLast  = SubCnt == SubCntWidth'(LimbCount);
    assign BitLast  = BitCnt == BitCntWidth'(OperandWidth - 1);
    assign LimbStep = State == Calc;
    assign Done     = State == Finish;

    // Sub-step counts limbs 0..LimbCount, bit counter counts result bits
    always_ff @(posedge Clk or negedge Resetn) begin
        if (!Resetn) begin
            SubCnt <= '0;
            BitCnt <= '0;
        end else if (State == Idle) begin
            SubCnt <= '0;
            BitCnt <= '0;
        end else if (LimbStep) begin
            if (SubLast) begin
                SubCnt <= '0;
                BitCnt <= BitCnt + 1'b1;
            end else begin
                SubCnt <= SubCnt + 1'b1;
            end
        end
    end

    // D and N are both odd when QBit is set, so (D - N) >>> 1 = (D >>> 1) - (N >> 1)
    assign ModShift  = {{LimbWidth{1'b0}}, Modulus} >> 1;
    assign DiffShift = $signed(Diff) >>> 1;

    // One shared limb adder, subtract by adding the complement plus one
    assign CurDiff = DiffShift[SubCnt];
    assign CurMod  = ModShift[SubCnt];
    assign Term    = QBit ? ~CurMod : '0;
    // The +1 of the complement enters at limb 0, later limbs take the stored carry
    assign CarryIn = (SubCnt == '0) ? QBit : Carry;
    assign LimbSum = {1'b0, CurDiff} + {1'b0, Term} + {{LimbWidth{1'b0}}, CarryIn};

    // Limbs go up in order, so limb i+1 still holds the old value when limb i reads it
    always_ff @(posedge Clk) begin
        if (Start && State == Idle) begin
            // Target value 1, its low bit is the first result bit
            Diff <= DiffWidth'(1);
            QBit <= 1'b1;
        end else if (LimbStep) begin
            Diff[SubCnt] <= LimbSum[LimbWidth-1:0];
            Carry        <= LimbSum[LimbWidth];
            // Limb 0 was rewritten at sub-step 0, its low bit is the next result bit
            if (SubLast) begin
                QBit <= Diff[0][0];
            end
        end
    end

    // Result enters from the top, bit 0 ends up at the bottom after all passes
    always_ff @(posedge Clk or negedge Resetn) begin
        if (!Resetn) begin
            Inverse <= OperandWidth'(1);
        end else if (LimbStep && SubLast) begin
            Inverse <= {QBit, Inverse[OperandWidth-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/MontPkg.sv ====
/*
  Shared widths, register map and engine states for the Montgomery setup stage.
  Imported by the Wishbone register block, the Q engine and the top level.
*/
`default_nettype none

package MontPkg;

    // Operand and engine datapath
    localparam int OperandWidth = 256;
    localparam int LimbWidth    = 64;
    localparam int LimbCount    = OperandWidth / LimbWidth;
    // Difference register carries one spare limb for the sign
    localparam int DiffWidth    = OperandWidth + LimbWidth;
    localparam int SubCntWidth  = $clog2(LimbCount + 1);
    localparam int BitCntWidth  = $clog2(OperandWidth);

    // Wishbone side
    localparam int BusWidth     = 32;
    localparam int BusWords     = OperandWidth / BusWidth;
    localparam int AdrWidth     = 8;
    // Byte address split into block, word index and byte offset
    localparam int WordLsb      = $clog2(BusWidth / 8);
    localparam int WordIdxWidth = $clog2(BusWords);
    localparam int BlockLsb     = WordLsb + WordIdxWidth;

    // Control and status bit positions
    localparam int CtrlStartBit  = 0;
    localparam int StatusBusyBit = 0;
    localparam int StatusDoneBit = 1;

    typedef enum logic [1:0] {
        Idle,
        Calc,
        Finish
    } QCalState;

    typedef enum logic [AdrWidth-1:0] {
        CtrlReg     = 8'h00,
        StatusReg   = 8'h04,
        ModulusBase = 8'h40,
        InverseBase = 8'h80
    } RegSel;

endpackage

`default_nettype wire
